/* project.f */
+incdir+src
+incdir+sim
src/umtrx_pkg.sv
src/wb_window_decode.sv
src/wb_settings_writer.sv
src/cmd_queue.sv
src/settings_arbiter.sv
src/setting_bank.sv
src/vita_timer.sv
src/readback_mux.sv
src/umtrx_ctrl_top.sv
sim/tb_umtrx_ctrl.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f project.f --top-module tb_umtrx_ctrl -o tb_sim

# The simulator exits non-zero on a fatal check, the log decides the result
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
   exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0

/* sim/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Settings window, register number at adr[9:2]
function automatic logic [15:0] set_addr(input int regnum);
   logic [7:0] r;
   r = 8'(regnum);
   return {6'b011100, r, 2'b00};
endfunction

// Readback window, word index at adr[5:2]
function automatic logic [15:0] rb_addr(input int idx);
   logic [3:0] i;
   i = 4'(idx);
   return {8'h5C, 2'b00, i, 2'b00};
endfunction

task automatic wait_cycles(input int n);
   repeat (n) @(negedge wb_clk);
endtask

// Setting registers update a couple of cycles after ack
task automatic settle();
   wait_cycles(3);
endtask

task automatic wb_access(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                         output logic [31:0] rdat, output int cycles);
   @(negedge wb_clk);
   wb_cyc_i = 1'b1;
   wb_stb_i = 1'b1;
   wb_we_i = we;
   wb_adr_i = adr;
   wb_dat_i = dat;
   cycles = 0;
   do begin
      @(negedge wb_clk);
      cycles++;
   end while (!wb_ack_o && cycles < ACK_LIMIT);
   if (!wb_ack_o) begin
      $display("Error at %0t: no Wishbone ack for address %h", $time, adr);
      abort_run();
   end
   rdat = wb_dat_o;
   wb_cyc_i = 1'b0;
   wb_stb_i = 1'b0;
   wb_we_i = 1'b0;
endtask

task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat, output int cycles);
   logic [31:0] unused;
   wb_access(1'b1, adr, dat, unused, cycles);
endtask

task automatic wb_read(input logic [15:0] adr, output logic [31:0] dat, output int cycles);
   wb_access(1'b0, adr, 32'h0, dat, cycles);
endtask

// High word first, then low; no carry within a few cycles
task automatic read_time(input int idx_hi, output logic [63:0] t);
   logic [31:0] hi, lo;
   int cyc;
   wb_read(rb_addr(idx_hi), hi, cyc);
   wb_read(rb_addr(idx_hi + 1), lo, cyc);
   t = {hi, lo};
endtask

// Starts on a falling edge, back to back calls transfer every cycle
task automatic cmd_push(input logic [7:0] addr, input logic [31:0] data);
   int n;
   n = 0;
   cmd_valid_i = 1'b1;
   cmd_addr_i = addr;
   cmd_data_i = data;
   // Command held while the queue is full
   while (!cmd_ready_o && n < ACK_LIMIT) begin
      @(negedge wb_clk);
      n++;
   end
   if (!cmd_ready_o) begin
      $display("Error at %0t: command queue stayed full", $time);
      abort_run();
   end
   @(negedge wb_clk);
   cmd_valid_i = 1'b0;
endtask

`endif

/* sim/tb_umtrx_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "umtrx_consts.svh"

module tb_umtrx_ctrl;

   localparam int CLK_PERIOD = 10;
   localparam int ACK_LIMIT = 100;
   // Rough cycle budget per test, summed for the watchdog
   localparam int RUN_CYCLES = 20 + 60 + 250 + 200 + 80 + 80 + 60;
   localparam logic [31:0] COMPAT_WORD = {16'd9, 16'd0};

   logic wb_clk;
   logic por_rst;
   logic wb_cyc_i, wb_stb_i, wb_we_i;
   logic [15:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [31:0] wb_dat_o;
   logic wb_ack_o;
   logic cmd_valid_i;
   logic [7:0] cmd_addr_i;
   logic [31:0] cmd_data_i;
   logic cmd_ready_o;
   logic pps_i, button_i;
   logic [7:0] leds_o;
   logic [1:0] lms_res_o;
   logic phy_resetn_o, divsw1_o, divsw2_o;

   logic [31:0] lfsr;
   int err_count;
   logic saw_full;
   logic pushes_done;

   umtrx_ctrl_top i_umtrx_ctrl_top (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .cmd_valid_i(cmd_valid_i), .cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i),
      .cmd_ready_o(cmd_ready_o),
      .pps_i(pps_i), .button_i(button_i),
      .leds_o(leds_o), .lms_res_o(lms_res_o), .phy_resetn_o(phy_resetn_o),
      .divsw1_o(divsw1_o), .divsw2_o(divsw2_o)
   );

   initial begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////
   // Error handling and random numbers

   task automatic abort_run();
      err_count++;
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_value(input string sig, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("ERR %0t %s got %0h expected %0h", $time, sig, got, exp);
         abort_run();
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      assert (cond) else begin
         $display("Error at %0t: %s", $time, msg);
         abort_run();
      end
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
         val = {val[30:0], lfsr_bit()};
      return val;
   endfunction

   // Per bit, source select 1 takes the hardware status
   function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw,
                                             input logic btn, input logic pps);
      logic [7:0] hw;
      logic [7:0] res;
      hw = {6'b0, pps, btn};
      for (int i = 0; i < 8; i++)
         res[i] = src[i] ? hw[i] : sw[i];
      return res;
   endfunction

   `include "tb_tasks.svh"

   always @(negedge wb_clk) begin
      if (por_rst)
         saw_full <= 1'b0;
      else if (!cmd_ready_o)
         saw_full <= 1'b1;
   end

   initial begin
      #(RUN_CYCLES * 2 * CLK_PERIOD);
      $display("Timeout: the run took longer than its cycle budget");
      abort_run();
   end

   ////////////////////////////////////////
   // Test sequence

   initial begin
      logic [31:0] rd, v, hi, lo, lo2, sw, src;
      logic [63:0] t_before, t_after, t_pps;
      int cyc;

      lfsr = 32'hdeab;
      err_count = 0;
      pushes_done = 1'b0;
      por_rst = 1'b1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      cmd_valid_i = 1'b0;
      cmd_addr_i = '0;
      cmd_data_i = '0;
      pps_i = 1'b0;
      button_i = 1'b0;
      repeat (3) @(negedge wb_clk);
      por_rst = 1'b0;
      @(negedge wb_clk);

      // Reset values
      check_value("leds_o", leds_o, 8'h00);
      check_value("divsw1_o", divsw1_o, 1'b1);
      check_value("divsw2_o", divsw2_o, 1'b1);
      check_value("phy_resetn_o", phy_resetn_o, 1'b1);
      check_value("lms_res_o", lms_res_o, 2'b00);
      check_value("cmd_ready_o", cmd_ready_o, 1'b1);
      wb_read(rb_addr(0), rd, cyc);
      check_value("wb_dat_o", rd, COMPAT_WORD);
      check_value("readback ack cycles", cyc, 1);

      // Settings through Wishbone
      v = rand_bits(2);
      wb_write(set_addr(`SR_MISC + 0), v, cyc);
      check_true(cyc >= 2, "settings write acked too early");
      settle();
      check_value("lms_res_o", lms_res_o, v[1:0]);
      wb_write(set_addr(`SR_MISC + 4), 32'd1, cyc);
      settle();
      check_value("phy_resetn_o", phy_resetn_o, 1'b0);
      wb_write(set_addr(`SR_MISC + 4), 32'd0, cyc);
      settle();
      check_value("phy_resetn_o", phy_resetn_o, 1'b1);
      wb_write(set_addr(`SR_DIVSW + 0), 32'd0, cyc);
      settle();
      check_value("divsw1_o", divsw1_o, 1'b0);
      check_value("divsw2_o", divsw2_o, 1'b1);
      wb_write(set_addr(`SR_DIVSW + 1), 32'd0, cyc);
      settle();
      check_value("divsw2_o", divsw2_o, 1'b0);
      sw = rand_bits(8);
      src = rand_bits(8);
      wb_write(set_addr(`SR_MISC + 3), sw, cyc);
      wb_write(set_addr(`SR_MISC + 6), src, cyc);
      button_i = 1'b1;
      settle();
      check_value("leds_o", leds_o, led_expect(src[7:0], sw[7:0], 1'b1, 1'b0));
      button_i = 1'b0;
      pps_i = 1'b1;
      @(negedge wb_clk);
      check_value("leds_o", leds_o, led_expect(src[7:0], sw[7:0], 1'b0, 1'b1));
      pps_i = 1'b0;
      @(negedge wb_clk);

      // Arbitration, command stream first
      v = rand_bits(2);
      fork
         begin
            for (int i = 0; i < 8; i++)
               cmd_push(8'(`SR_MISC + 0), ~v);
            pushes_done = 1'b1;
         end
         begin
            repeat (2) @(negedge wb_clk);
            wb_write(set_addr(`SR_MISC + 0), v, cyc);
            check_true(pushes_done, "Wishbone ack came before the queue drained");
         end
      join
      check_true(saw_full, "cmd_ready_o never went low with a full queue");
      settle();
      check_value("lms_res_o", lms_res_o, v[1:0]);
      check_value("cmd_ready_o", cmd_ready_o, 1'b1);

      // Time set and count
      hi = rand_bits(32);
      lo = rand_bits(31);
      cmd_push(8'(`SR_TIME64 + 0), hi);
      cmd_push(8'(`SR_TIME64 + 1), lo);
      wait_cycles(8);
      wb_read(rb_addr(2), rd, cyc);
      check_value("time high", rd, hi);
      wb_read(rb_addr(3), lo2, cyc);
      check_true(lo2 >= lo, "time low word below the loaded value");
      wb_read(rb_addr(3), rd, cyc);
      check_true(rd > lo2, "time counter did not advance");

      // PPS latch
      read_time(2, t_before);
      pps_i = 1'b1;
      wait_cycles(8);
      read_time(2, t_after);
      read_time(4, t_pps);
      check_true(t_pps > t_before, "PPS time not after the first reading");
      check_true(t_pps < t_after, "PPS time not before the second reading");
      pps_i = 1'b0;

      // Decode
      wb_read(16'h1234, rd, cyc);
      check_value("unmapped wb_dat_o", rd, 32'h0);
      check_value("unmapped ack cycles", cyc, 1);
      v = {30'b0, lms_res_o};
      wb_write(rb_addr(0), 32'hffff_ffff, cyc);
      check_value("readback write ack cycles", cyc, 1);
      settle();
      check_value("lms_res_o", lms_res_o, v[1:0]);
      wb_read(rb_addr(0), rd, cyc);
      check_value("wb_dat_o", rd, COMPAT_WORD);
      wb_read(rb_addr(9), rd, cyc);
      check_value("unused wb_dat_o", rd, 32'h0);

      if (err_count == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         abort_run();
      end
   end

endmodule

`default_nettype wire

/* src/umtrx_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module umtrx_ctrl_top (
   input  wire                 wb_clk,
   input  wire                 por_rst,
   // Wishbone slave
   input  wire                 wb_cyc_i,
   input  wire                 wb_stb_i,
   input  wire                 wb_we_i,
   input  umtrx_pkg::wb_adr_t  wb_adr_i,
   input  umtrx_pkg::wb_dat_t  wb_dat_i,
   output umtrx_pkg::wb_dat_t  wb_dat_o,
   output logic                wb_ack_o,
   // Command stream
   input  wire                 cmd_valid_i,
   input  umtrx_pkg::set_addr_t cmd_addr_i,
   input  umtrx_pkg::set_data_t cmd_data_i,
   output logic                cmd_ready_o,
   // Board I/O
   input  wire                 pps_i,
   input  wire                 button_i,
   output logic [7:0]          leds_o,
   output logic [1:0]          lms_res_o,
   output logic                phy_resetn_o,
   output logic                divsw1_o,
   output logic                divsw2_o
);

   import umtrx_pkg::*;

   logic win_set_stb, win_set_ack;
   logic win_rb_stb, win_rb_ack;
   wb_dat_t rb_dat;

   logic wb_req, wb_gnt;
   set_addr_t wb_req_addr;
   set_data_t wb_req_data;

   logic cmd_req, cmd_gnt;
   set_addr_t cmd_req_addr;
   set_data_t cmd_req_data;

   logic set_bus_stb;
   set_addr_t set_bus_addr;
   set_data_t set_bus_data;

   vita_time_t vita_time, vita_time_pps;

   ////////////////////////////////////////
   // Wishbone side

   wb_window_decode i_wb_window_decode (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_adr_i(wb_adr_i),
      .set_stb_o(win_set_stb), .set_ack_i(win_set_ack),
      .rb_stb_o(win_rb_stb), .rb_ack_i(win_rb_ack), .rb_dat_i(rb_dat),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o)
   );

   wb_settings_writer i_wb_settings_writer (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .stb_i(win_set_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .ack_o(win_set_ack),
      .req_o(wb_req), .req_addr_o(wb_req_addr), .req_data_o(wb_req_data),
      .gnt_i(wb_gnt)
   );

   readback_mux i_readback_mux (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .stb_i(win_rb_stb), .adr_i(wb_adr_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps), .button_i(button_i),
      .dat_o(rb_dat), .ack_o(win_rb_ack)
   );

   ////////////////////////////////////////
   // Command stream and settings bus

   cmd_queue i_cmd_queue (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .cmd_valid_i(cmd_valid_i), .cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i),
      .cmd_ready_o(cmd_ready_o),
      .req_o(cmd_req), .req_addr_o(cmd_req_addr), .req_data_o(cmd_req_data),
      .gnt_i(cmd_gnt)
   );

   settings_arbiter i_settings_arbiter (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .cmd_req_i(cmd_req), .cmd_addr_i(cmd_req_addr), .cmd_data_i(cmd_req_data),
      .cmd_gnt_o(cmd_gnt),
      .wb_req_i(wb_req), .wb_addr_i(wb_req_addr), .wb_data_i(wb_req_data),
      .wb_gnt_o(wb_gnt),
      .set_stb_o(set_bus_stb), .set_addr_o(set_bus_addr), .set_data_o(set_bus_data)
   );

   setting_bank i_setting_bank (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .set_stb_i(set_bus_stb), .set_addr_i(set_bus_addr), .set_data_i(set_bus_data),
      .pps_i(pps_i), .button_i(button_i),
      .leds_o(leds_o), .lms_res_o(lms_res_o), .phy_resetn_o(phy_resetn_o),
      .divsw1_o(divsw1_o), .divsw2_o(divsw2_o)
   );

   vita_timer i_vita_timer (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .set_stb_i(set_bus_stb), .set_addr_i(set_bus_addr), .set_data_i(set_bus_data),
      .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

endmodule

`default_nettype wire

/* src/readback_mux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "umtrx_consts.svh"

module readback_mux (
   input  wire                    wb_clk,
   input  wire                    por_rst,
   input  wire                    stb_i,
   input  umtrx_pkg::wb_adr_t     adr_i,
   input  umtrx_pkg::vita_time_t  vita_time_i,
   input  umtrx_pkg::vita_time_t  vita_time_pps_i,
   input  wire                    button_i,
   output umtrx_pkg::wb_dat_t     dat_o,
   output logic                   ack_o
);

   import umtrx_pkg::*;

   wb_dat_t word;

   always_comb begin
      case (adr_i[5:2])
         4'd0: word = {`COMPAT_MAJOR, `COMPAT_MINOR};
         4'd1: word = {31'b0, button_i};
         4'd2: word = vita_time_i[63:32];
         4'd3: word = vita_time_i[31:0];
         4'd4: word = vita_time_pps_i[63:32];
         4'd5: word = vita_time_pps_i[31:0];
         default: word = '0;
      endcase
   end

   // Writes land here too and are simply acked
   always_ff @(posedge wb_clk) begin
      if (por_rst)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;
   end

   always_ff @(posedge wb_clk) begin
      dat_o <= word;
   end

endmodule

`default_nettype wire

/* src/vita_timer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "umtrx_consts.svh"

module vita_timer (
   input  wire                    wb_clk,
   input  wire                    por_rst,
   input  wire                    set_stb_i,
   input  umtrx_pkg::set_addr_t   set_addr_i,
   input  umtrx_pkg::set_data_t   set_data_i,
   input  wire                    pps_i,
   output umtrx_pkg::vita_time_t  vita_time_o,
   output umtrx_pkg::vita_time_t  vita_time_pps_o
);

   import umtrx_pkg::*;

   localparam set_addr_t ADDR_TIME_HI = set_addr_t'(`SR_TIME64 + 0);
   localparam set_addr_t ADDR_TIME_LO = set_addr_t'(`SR_TIME64 + 1);

   logic [31:0] time_hi_stage;
   logic load_time;
   // Two sync flops plus one for edge detect
   logic [2:0] pps_sr;
   logic pps_rise;

   assign load_time = set_stb_i & (set_addr_i == ADDR_TIME_LO);

   always_ff @(posedge wb_clk) begin
      if (set_stb_i && (set_addr_i == ADDR_TIME_HI))
         time_hi_stage <= set_data_i;
   end

   always_ff @(posedge wb_clk) begin
      if (por_rst)
         vita_time_o <= '0;
      else if (load_time)
         vita_time_o <= {time_hi_stage, set_data_i};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

   assign pps_rise = pps_sr[1] & ~pps_sr[2];

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         pps_sr <= 3'b000;
         vita_time_pps_o <= '0;
      end else begin
         pps_sr <= {pps_sr[1:0], pps_i};
         if (pps_rise)
            vita_time_pps_o <= vita_time_o;
      end
   end

endmodule

`default_nettype wire

/* src/setting_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "umtrx_consts.svh"

module setting_bank (
   input  wire                  wb_clk,
   input  wire                  por_rst,
   input  wire                  set_stb_i,
   input  umtrx_pkg::set_addr_t set_addr_i,
   input  umtrx_pkg::set_data_t set_data_i,
   input  wire                  pps_i,
   input  wire                  button_i,
   output logic [7:0]           leds_o,
   output logic [1:0]           lms_res_o,
   output logic                 phy_resetn_o,
   output logic                 divsw1_o,
   output logic                 divsw2_o
);

   import umtrx_pkg::*;

   localparam set_addr_t ADDR_LMS_RES = set_addr_t'(`SR_MISC + 0);
   localparam set_addr_t ADDR_LED_SW = set_addr_t'(`SR_MISC + 3);
   localparam set_addr_t ADDR_PHY = set_addr_t'(`SR_MISC + 4);
   localparam set_addr_t ADDR_LED_SRC = set_addr_t'(`SR_MISC + 6);
   localparam set_addr_t ADDR_DIVSW1 = set_addr_t'(`SR_DIVSW + 0);
   localparam set_addr_t ADDR_DIVSW2 = set_addr_t'(`SR_DIVSW + 1);

   logic [7:0] led_sw, led_src, led_hw;
   logic phy_reset;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         lms_res_o <= 2'b00;
         led_sw <= 8'h00;
         phy_reset <= 1'b0;
         led_src <= `LED_SRC_RESET;
         divsw1_o <= `DIVSW_RESET;
         divsw2_o <= `DIVSW_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            ADDR_LMS_RES: lms_res_o <= set_data_i[1:0];
            ADDR_LED_SW: led_sw <= set_data_i[7:0];
            ADDR_PHY: phy_reset <= set_data_i[0];
            ADDR_LED_SRC: led_src <= set_data_i[7:0];
            ADDR_DIVSW1: divsw1_o <= set_data_i[0];
            ADDR_DIVSW2: divsw2_o <= set_data_i[0];
            default: ;
         endcase
      end
   end

   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////
   // LEDs, src bit 1 = hardware, 0 = software

   assign led_hw = {6'b0, pps_i, button_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

/* src/settings_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module settings_arbiter (
   input  wire                  wb_clk,
   input  wire                  por_rst,
   input  wire                  cmd_req_i,
   input  umtrx_pkg::set_addr_t cmd_addr_i,
   input  umtrx_pkg::set_data_t cmd_data_i,
   output logic                 cmd_gnt_o,
   input  wire                  wb_req_i,
   input  umtrx_pkg::set_addr_t wb_addr_i,
   input  umtrx_pkg::set_data_t wb_data_i,
   output logic                 wb_gnt_o,
   output logic                 set_stb_o,
   output umtrx_pkg::set_addr_t set_addr_o,
   output umtrx_pkg::set_data_t set_data_o
);

   import umtrx_pkg::*;

   grant_e gnt_q;
   grant_e pick;

   // Command stream first; dead cycle after every grant
   always_comb begin
      if (gnt_q != GNT_NONE)
         pick = GNT_NONE;
      else if (cmd_req_i)
         pick = GNT_CMD;
      else if (wb_req_i)
         pick = GNT_WB;
      else
         pick = GNT_NONE;
   end

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         gnt_q <= GNT_NONE;
         set_stb_o <= 1'b0;
      end else begin
         gnt_q <= pick;
         set_stb_o <= (gnt_q != GNT_NONE);
      end
   end

   // Payload taken with the grant, strobed one cycle later
   always_ff @(posedge wb_clk) begin
      if (pick != GNT_NONE) begin
         set_addr_o <= (pick == GNT_CMD) ? cmd_addr_i : wb_addr_i;
         set_data_o <= (pick == GNT_CMD) ? cmd_data_i : wb_data_i;
      end
   end

   assign cmd_gnt_o = (gnt_q == GNT_CMD);
   assign wb_gnt_o = (gnt_q == GNT_WB);

endmodule

`default_nettype wire

/* src/cmd_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "umtrx_consts.svh"

module cmd_queue (
   input  wire                  wb_clk,
   input  wire                  por_rst,
   input  wire                  cmd_valid_i,
   input  umtrx_pkg::set_addr_t cmd_addr_i,
   input  umtrx_pkg::set_data_t cmd_data_i,
   output logic                 cmd_ready_o,
   output logic                 req_o,
   output umtrx_pkg::set_addr_t req_addr_o,
   output umtrx_pkg::set_data_t req_data_o,
   input  wire                  gnt_i
);

   import umtrx_pkg::*;

   localparam int DEPTH = 1 << `CMDQ_AW;

   set_addr_t addr_mem [DEPTH];
   set_data_t data_mem [DEPTH];
   logic [`CMDQ_AW-1:0] wr_ptr, rd_ptr;
   logic [`CMDQ_AW:0] count;
   logic push, pop;

   // Top count bit is set only when all entries are in use
   assign cmd_ready_o = ~count[`CMDQ_AW];
   assign req_o = (count != '0);
   assign push = cmd_valid_i & cmd_ready_o;
   assign pop = gnt_i & req_o;

   always_ff @(posedge wb_clk) begin
      if (push) begin
         addr_mem[wr_ptr] <= cmd_addr_i;
         data_mem[wr_ptr] <= cmd_data_i;
      end
   end

   ////////////////////////////////////////
   // Pointers and fill level

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head entry stays put until granted
   assign req_addr_o = addr_mem[rd_ptr];
   assign req_data_o = data_mem[rd_ptr];

endmodule

`default_nettype wire

/* src/wb_settings_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_settings_writer (
   input  wire                  wb_clk,
   input  wire                  por_rst,
   input  wire                  stb_i,
   input  wire                  we_i,
   input  umtrx_pkg::wb_adr_t   adr_i,
   input  umtrx_pkg::wb_dat_t   dat_i,
   output logic                 ack_o,
   output logic                 req_o,
   output umtrx_pkg::set_addr_t req_addr_o,
   output umtrx_pkg::set_data_t req_data_o,
   input  wire                  gnt_i
);

   import umtrx_pkg::*;

   wr_state_e state;
   logic wr_start;
   logic rd_ack;

   assign wr_start = (state == WR_IDLE) & stb_i & we_i;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state <= WR_IDLE;
         rd_ack <= 1'b0;
      end else begin
         // Window is write-only, reads just terminate
         rd_ack <= stb_i & ~we_i & ~rd_ack;
         if (wr_start)
            state <= WR_PEND;
         else if ((state == WR_PEND) && gnt_i)
            state <= WR_IDLE;
      end
   end

   // Word address into the settings space
   always_ff @(posedge wb_clk) begin
      if (wr_start) begin
         req_addr_o <= adr_i[9:2];
         req_data_o <= dat_i;
      end
   end

   assign req_o = (state == WR_PEND);
   // Master is held until the bus is ours
   assign ack_o = (req_o & gnt_i) | rd_ack;

endmodule

`default_nettype wire

/* src/wb_window_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "umtrx_consts.svh"

module wb_window_decode (
   input  wire                 wb_clk,
   input  wire                 por_rst,
   input  wire                 wb_cyc_i,
   input  wire                 wb_stb_i,
   input  umtrx_pkg::wb_adr_t  wb_adr_i,
   output logic                set_stb_o,
   input  wire                 set_ack_i,
   output logic                rb_stb_o,
   input  wire                 rb_ack_i,
   input  umtrx_pkg::wb_dat_t  rb_dat_i,
   output logic                wb_ack_o,
   output umtrx_pkg::wb_dat_t  wb_dat_o
);

   import umtrx_pkg::*;

   win_e win;
   logic [7:0] top_byte;
   logic bus_stb;
   logic nm_ack;

   assign top_byte = wb_adr_i[`WB_AW-1:`WB_AW-8];
   assign bus_stb = wb_cyc_i & wb_stb_i;

   always_comb begin
      if ((top_byte & `WIN_SET_MASK) == `WIN_SET_BASE)
         win = WIN_SET;
      else if ((top_byte & `WIN_RB_MASK) == `WIN_RB_BASE)
         win = WIN_RB;
      else
         win = WIN_NONE;
   end

   assign set_stb_o = bus_stb & (win == WIN_SET);
   assign rb_stb_o = bus_stb & (win == WIN_RB);

   // Unmapped addresses still terminate, one cycle later
   always_ff @(posedge wb_clk) begin
      if (por_rst)
         nm_ack <= 1'b0;
      else
         nm_ack <= bus_stb & (win == WIN_NONE) & ~nm_ack;
   end

   assign wb_ack_o = set_ack_i | rb_ack_i | nm_ack;
   // Only the readback window returns data
   assign wb_dat_o = (win == WIN_RB) ? rb_dat_i : '0;

endmodule

`default_nettype wire

/* src/umtrx_pkg.sv */
`default_nettype none

`include "umtrx_consts.svh"

package umtrx_pkg;

   typedef logic [`SET_AW-1:0] set_addr_t;
   typedef logic [`WB_DW-1:0] set_data_t;
   typedef logic [`WB_AW-1:0] wb_adr_t;
   typedef logic [`WB_DW-1:0] wb_dat_t;
   typedef logic [63:0] vita_time_t;

   // Address window seen by the decoder
   typedef enum logic [1:0] {WIN_NONE, WIN_SET, WIN_RB} win_e;

   typedef enum logic {WR_IDLE, WR_PEND} wr_state_e;

   // Current owner of the settings bus
   typedef enum logic [1:0] {GNT_NONE, GNT_CMD, GNT_WB} grant_e;

endpackage

`default_nettype wire

/* src/umtrx_consts.svh */
`ifndef UMTRX_CONSTS_SVH
`define UMTRX_CONSTS_SVH

// Bus widths
`define WB_AW 16
`define WB_DW 32
`define SET_AW 8

// Settings bus register bases
`define SR_MISC 0
`define SR_TIME64 10
`define SR_DIVSW 180

// Wishbone windows, matched on the top address byte
`define WIN_SET_BASE 8'h70
`define WIN_SET_MASK 8'hF0
`define WIN_RB_BASE 8'h5C
`define WIN_RB_MASK 8'hFC

// Compatibility number, bump on incompatible changes
`define COMPAT_MAJOR 16'd9
`define COMPAT_MINOR 16'd0

`define CMDQ_AW 2

`define LED_SRC_RESET 8'h1E
`define DIVSW_RESET 1'b1

`endif
